/* src/snes_cart_params.svh */
`ifndef SNES_CART_PARAMS_SVH
`define SNES_CART_PARAMS_SVH

// Console strobe filter
`define SNES_EDGE_DEPTH 8

// PSRAM wait counts, in clk2 cycles beyond the first
`define ROM_RD_WAIT     4'd4
`define ROM_RD_WAIT_MCU 4'd6
`define ROM_WR_WAIT1    4'd2
`define ROM_WR_WAIT2    4'd3
`define ROM_WR_WAIT_MCU 4'd6
`define MCU_TAIL_WAIT   4'd2

// Save RAM window on the console bus and its place in PSRAM
`define SAVERAM_BANK_LO 8'h70
`define SAVERAM_BANK_HI 8'h7D
`define SAVERAM_BASE    24'hE00000

`endif

/* src/snes_bus_pkg.sv */
package snes_bus_pkg;

  // Console address as seen on the cartridge edge
  typedef logic [23:0] snes_addr_t;

  typedef logic [7:0] snes_byte_t;

  // Where a console address lands
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_SAVERAM,
    REGION_NONE
  } mem_region_e;

endpackage

/* src/mem_pkg.sv */
package mem_pkg;

  // PSRAM byte address, bit 0 picks the lane
  typedef logic [23:0] rom_addr_t;

  typedef logic [15:0] rom_word_t;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } mem_op_e;

  // Access sequencer states
  typedef enum logic [4:0] {
    ST_IDLE,
    ST_SNES_RD_ADDR,
    ST_SNES_RD_WAIT,
    ST_SNES_RD_END,
    ST_SNES_WR_ADDR,
    ST_SNES_WR_WAIT1,
    ST_SNES_WR_DATA,
    ST_SNES_WR_WAIT2,
    ST_SNES_WR_END,
    ST_MCU_RD_ADDR,
    ST_MCU_RD_WAIT,
    ST_MCU_RD_WAIT2,
    ST_MCU_RD_END,
    ST_MCU_WR_ADDR,
    ST_MCU_WR_WAIT,
    ST_MCU_WR_WAIT2,
    ST_MCU_WR_END
  } mem_state_e;

endpackage

/* src/rom_req_if.sv */
`timescale 1ns/10ps

interface rom_req_if;

  // Strobe on the console side, level until done on the MCU side
  logic                     req;
  mem_pkg::mem_op_e         op;
  mem_pkg::rom_addr_t       addr;
  snes_bus_pkg::snes_byte_t wdata;

  // Read byte stays put until the next access
  snes_bus_pkg::snes_byte_t rdata;
  logic                     done;

  modport requester (
    output req, op, addr, wdata,
    input  rdata, done
  );

  modport arbiter (
    input  req, op, addr, wdata,
    output rdata, done
  );

endinterface

/* src/snes_bus_sync.sv */
`timescale 1ns/10ps

`include "snes_cart_params.svh"

module snes_bus_sync (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  snes_bus_pkg::snes_addr_t snes_addr_in,
  input  logic                     snes_cpu_clk,
  input  logic                     snes_write,
  output snes_bus_pkg::snes_addr_t snes_addr,
  output logic                     cycle_start,
  output logic                     wr_start,
  output logic                     wr_active
);

  localparam int DEPTH = `SNES_EDGE_DEPTH;

  snes_bus_pkg::snes_addr_t addr_q [3];
  logic [DEPTH-1:0]         cpu_clk_q;
  logic [DEPTH-1:0]         write_q;
  logic [DEPTH-3:0]         clk_hi;
  logic                     clk_rise;

  //////////////////////////////////////////////////
  // Address glitch filter

  always_ff @(posedge clk2) begin
    addr_q[2] <= addr_q[1];
    addr_q[1] <= addr_q[0];
    addr_q[0] <= snes_addr_in;
  end

  // A bit only counts once it held for two samples
  assign snes_addr = addr_q[2] & addr_q[1];

  //////////////////////////////////////////////////
  // Strobe edge detection

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      cpu_clk_q <= '1;
      write_q   <= '1;
    end else begin
      cpu_clk_q <= {cpu_clk_q[DEPTH-2:0], snes_cpu_clk};
      write_q   <= {write_q[DEPTH-2:0], snes_write};
    end
  end

  // CPU clock rise, pairs ANDed to mask single-sample spikes
  assign clk_hi   = cpu_clk_q[DEPTH-1:2] & cpu_clk_q[DEPTH-2:1];
  assign clk_rise = (clk_hi == {{(DEPTH-3){1'b0}}, 1'b1});

  // Write strobe fall after a quiet high run
  assign wr_start = (write_q[DEPTH-1:1] == {{(DEPTH-2){1'b1}}, 1'b0});

  assign cycle_start = clk_rise & ~wr_start;
  assign wr_active   = ~(write_q[0] | write_q[1]);

endmodule

/* src/snes_port.sv */
`timescale 1ns/10ps

`include "snes_cart_params.svh"

module snes_port (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  snes_bus_pkg::snes_addr_t snes_addr,
  input  logic                     cycle_start,
  input  logic                     wr_start,
  input  logic                     snes_read,
  input  snes_bus_pkg::snes_byte_t snes_data_in,
  input  mem_pkg::rom_addr_t       rom_mask,
  input  mem_pkg::rom_addr_t       saveram_mask,
  output snes_bus_pkg::snes_byte_t snes_data_out,
  output logic                     snes_data_oe,
  rom_req_if.requester             rom_req
);

  logic [7:0]                  bank;
  snes_bus_pkg::mem_region_e   region;
  mem_pkg::rom_addr_t          mapped_addr;
  logic                        rd_issue;
  logic                        wr_issue;
  logic                        req_q;
  mem_pkg::mem_op_e            op_q;
  mem_pkg::rom_addr_t          addr_q;

  assign bank = snes_addr[23:16];

  //////////////////////////////////////////////////
  // LoROM-style decode

  always_comb begin
    if (bank >= `SAVERAM_BANK_LO && bank <= `SAVERAM_BANK_HI && !snes_addr[15]) begin
      region      = snes_bus_pkg::REGION_SAVERAM;
      mapped_addr = `SAVERAM_BASE + ({9'd0, snes_addr[14:0]} & saveram_mask);
    end else if (bank == 8'h7E || bank == 8'h7F) begin
      // WRAM banks belong to the console
      region      = snes_bus_pkg::REGION_NONE;
      mapped_addr = '0;
    end else begin
      region      = snes_bus_pkg::REGION_ROM;
      mapped_addr = {2'b00, bank[6:0], snes_addr[14:0]} & rom_mask;
    end
  end

  // ROM writes never leave this port
  assign rd_issue = cycle_start;
  assign wr_issue = wr_start && (region == snes_bus_pkg::REGION_SAVERAM);

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
      op_q  <= mem_pkg::OP_READ;
    end else begin
      req_q <= rd_issue | wr_issue;
      if (wr_issue) begin
        op_q <= mem_pkg::OP_WRITE;
      end else if (rd_issue) begin
        op_q <= mem_pkg::OP_READ;
      end
    end
  end

  always_ff @(posedge clk2) begin
    if (rd_issue || wr_issue) begin
      addr_q <= mapped_addr;
    end
  end

  assign rom_req.req   = req_q;
  assign rom_req.op    = op_q;
  assign rom_req.addr  = addr_q;
  // Console data is sampled late in the write, by the arbiter
  assign rom_req.wdata = snes_data_in;

  assign snes_data_out = rom_req.rdata;
  assign snes_data_oe  = ~snes_read & (region != snes_bus_pkg::REGION_NONE);

  // A console write into ROM space starts no access at all
  a_no_rom_write: assert property (@(posedge clk2) disable iff (!rst_n)
    (wr_start && region == snes_bus_pkg::REGION_ROM) |=> !rom_req.req);

endmodule

/* src/mcu_port.sv */
`timescale 1ns/10ps

module mcu_port (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  mem_pkg::rom_addr_t       mcu_addr,
  input  snes_bus_pkg::snes_byte_t mcu_wdata,
  output logic                     mcu_rdy,
  output snes_bus_pkg::snes_byte_t mcu_rdata,
  rom_req_if.requester             rom_req
);

  logic                     rdy_q;
  logic                     req_q;
  logic                     accept;
  mem_pkg::mem_op_e         op_q;
  mem_pkg::rom_addr_t       addr_q;
  snes_bus_pkg::snes_byte_t wdata_q;
  snes_bus_pkg::snes_byte_t rdata_q;

  // Requests while busy are dropped
  assign accept = rdy_q & (mcu_rrq | mcu_wrq);

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      rdy_q <= 1'b1;
      req_q <= 1'b0;
      op_q  <= mem_pkg::OP_READ;
    end else if (accept) begin
      rdy_q <= 1'b0;
      req_q <= 1'b1;
      op_q  <= mcu_wrq ? mem_pkg::OP_WRITE : mem_pkg::OP_READ;
    end else if (rom_req.done) begin
      rdy_q <= 1'b1;
      req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk2) begin
    if (accept) begin
      addr_q  <= mcu_addr;
      wdata_q <= mcu_wdata;
    end
    if (rom_req.done && op_q == mem_pkg::OP_READ) begin
      rdata_q <= rom_req.rdata;
    end
  end

  // Held until done, a console access may restart it meanwhile
  assign rom_req.req   = req_q;
  assign rom_req.op    = op_q;
  assign rom_req.addr  = addr_q;
  assign rom_req.wdata = wdata_q;

  assign mcu_rdy   = rdy_q;
  assign mcu_rdata = rdata_q;

  a_one_request: assert property (@(posedge clk2) disable iff (!rst_n)
    !(mcu_rrq && mcu_wrq));

endmodule

/* src/rom_arbiter.sv */
`timescale 1ns/10ps

`include "snes_cart_params.svh"

module rom_arbiter (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  snes_bus_pkg::snes_byte_t rd_byte,
  rom_req_if.arbiter               snes_req,
  rom_req_if.arbiter               mcu_req,
  output mem_pkg::rom_addr_t       rom_addr,
  output snes_bus_pkg::snes_byte_t wr_byte,
  output logic                     rom_we
);

  mem_pkg::mem_state_e      state;
  logic [3:0]               delay_q;
  logic                     we_q;
  mem_pkg::rom_addr_t       addr_q;
  snes_bus_pkg::snes_byte_t wr_byte_q;
  snes_bus_pkg::snes_byte_t snes_rdata_q;
  snes_bus_pkg::snes_byte_t mcu_rdata_q;

  //////////////////////////////////////////////////
  // Access sequencer

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      state   <= mem_pkg::ST_IDLE;
      delay_q <= 4'd0;
      we_q    <= 1'b1;
    end else if (snes_req.req) begin
      // Console wins at once, a running MCU access starts over later
      we_q <= 1'b1;
      if (snes_req.op == mem_pkg::OP_WRITE) begin
        state <= mem_pkg::ST_SNES_WR_ADDR;
      end else begin
        state <= mem_pkg::ST_SNES_RD_ADDR;
      end
    end else begin
      case (state)
        mem_pkg::ST_IDLE: begin
          if (mcu_req.req) begin
            if (mcu_req.op == mem_pkg::OP_WRITE) begin
              state <= mem_pkg::ST_MCU_WR_ADDR;
            end else begin
              state <= mem_pkg::ST_MCU_RD_ADDR;
            end
          end
        end
        mem_pkg::ST_SNES_RD_ADDR: begin
          delay_q <= `ROM_RD_WAIT;
          state   <= mem_pkg::ST_SNES_RD_WAIT;
        end
        mem_pkg::ST_SNES_RD_WAIT: begin
          delay_q <= delay_q - 4'd1;
          if (delay_q == 4'd0) begin
            state <= mem_pkg::ST_SNES_RD_END;
          end
        end
        mem_pkg::ST_SNES_WR_ADDR: begin
          we_q    <= 1'b0;
          delay_q <= `ROM_WR_WAIT1;
          state   <= mem_pkg::ST_SNES_WR_WAIT1;
        end
        mem_pkg::ST_SNES_WR_WAIT1: begin
          delay_q <= delay_q - 4'd1;
          if (delay_q == 4'd0) begin
            state <= mem_pkg::ST_SNES_WR_DATA;
          end
        end
        mem_pkg::ST_SNES_WR_DATA: begin
          delay_q <= `ROM_WR_WAIT2;
          state   <= mem_pkg::ST_SNES_WR_WAIT2;
        end
        mem_pkg::ST_SNES_WR_WAIT2: begin
          delay_q <= delay_q - 4'd1;
          if (delay_q == 4'd0) begin
            state <= mem_pkg::ST_SNES_WR_END;
          end
        end
        mem_pkg::ST_SNES_WR_END: begin
          we_q  <= 1'b1;
          state <= mem_pkg::ST_IDLE;
        end
        mem_pkg::ST_MCU_RD_ADDR: begin
          delay_q <= `ROM_RD_WAIT_MCU;
          state   <= mem_pkg::ST_MCU_RD_WAIT;
        end
        mem_pkg::ST_MCU_RD_WAIT: begin
          delay_q <= delay_q - 4'd1;
          if (delay_q == 4'd0) begin
            delay_q <= `MCU_TAIL_WAIT;
            state   <= mem_pkg::ST_MCU_RD_WAIT2;
          end
        end
        mem_pkg::ST_MCU_WR_ADDR: begin
          we_q    <= 1'b0;
          delay_q <= `ROM_WR_WAIT_MCU;
          state   <= mem_pkg::ST_MCU_WR_WAIT;
        end
        mem_pkg::ST_MCU_WR_WAIT: begin
          delay_q <= delay_q - 4'd1;
          if (delay_q == 4'd0) begin
            we_q    <= 1'b1;
            delay_q <= `MCU_TAIL_WAIT;
            state   <= mem_pkg::ST_MCU_WR_WAIT2;
          end
        end
        mem_pkg::ST_MCU_RD_WAIT2,
        mem_pkg::ST_MCU_WR_WAIT2: begin
          // Recovery gap before the PSRAM sees another address
          delay_q <= delay_q - 4'd1;
          if (delay_q == 4'd0) begin
            state <= (state == mem_pkg::ST_MCU_RD_WAIT2) ? mem_pkg::ST_MCU_RD_END
                                                         : mem_pkg::ST_MCU_WR_END;
          end
        end
        default: begin
          state <= mem_pkg::ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Address, write byte and read capture

  always_ff @(posedge clk2) begin
    case (state)
      mem_pkg::ST_SNES_RD_ADDR,
      mem_pkg::ST_SNES_WR_ADDR: addr_q <= snes_req.addr;
      mem_pkg::ST_SNES_WR_DATA: wr_byte_q <= snes_req.wdata;
      mem_pkg::ST_SNES_RD_WAIT: snes_rdata_q <= rd_byte;
      mem_pkg::ST_MCU_RD_ADDR:  addr_q <= mcu_req.addr;
      mem_pkg::ST_MCU_RD_WAIT:  mcu_rdata_q <= rd_byte;
      mem_pkg::ST_MCU_WR_ADDR: begin
        addr_q    <= mcu_req.addr;
        wr_byte_q <= mcu_req.wdata;
      end
      default: begin
      end
    endcase
  end

  assign snes_req.rdata = snes_rdata_q;
  assign snes_req.done  = (state == mem_pkg::ST_SNES_RD_END) ||
                          (state == mem_pkg::ST_SNES_WR_END);
  assign mcu_req.rdata  = mcu_rdata_q;
  assign mcu_req.done   = (state == mem_pkg::ST_MCU_RD_END) ||
                          (state == mem_pkg::ST_MCU_WR_END);

  assign rom_addr = addr_q;
  assign wr_byte  = wr_byte_q;
  assign rom_we   = we_q;

  a_we_in_write: assert property (@(posedge clk2) disable iff (!rst_n)
    !rom_we |-> state inside {mem_pkg::ST_SNES_WR_WAIT1, mem_pkg::ST_SNES_WR_DATA,
                              mem_pkg::ST_SNES_WR_WAIT2, mem_pkg::ST_SNES_WR_END,
                              mem_pkg::ST_MCU_WR_WAIT});

endmodule

/* src/rom_bus_drive.sv */
`timescale 1ns/10ps

module rom_bus_drive (
  input  mem_pkg::rom_addr_t       rom_addr,
  input  snes_bus_pkg::snes_byte_t wr_byte,
  input  logic                     rom_we,
  input  mem_pkg::rom_word_t       rom_dq_in,
  output logic [22:0]              rom_addr_word,
  output logic                     rom_bhe,
  output logic                     rom_ble,
  output mem_pkg::rom_word_t       rom_dq_out,
  output logic                     rom_dq_oe,
  output snes_bus_pkg::snes_byte_t rd_byte
);

  logic lane_lo;

  // Odd byte addresses live in the low half of the word
  assign lane_lo       = rom_addr[0];
  assign rom_addr_word = rom_addr[23:1];

  assign rom_ble = ~lane_lo;
  assign rom_bhe = lane_lo;

  assign rom_dq_out = lane_lo ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rom_dq_oe  = ~rom_we;

  assign rd_byte = lane_lo ? rom_dq_in[7:0] : rom_dq_in[15:8];

endmodule

/* src/snes_cart_top.sv */
`timescale 1ns/10ps

module snes_cart_top (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  snes_bus_pkg::snes_addr_t snes_addr_in,
  input  logic                     snes_read,
  input  logic                     snes_write,
  input  logic                     snes_cpu_clk,
  input  snes_bus_pkg::snes_byte_t snes_data_in,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  mem_pkg::rom_addr_t       mcu_addr,
  input  snes_bus_pkg::snes_byte_t mcu_wdata,
  input  mem_pkg::rom_addr_t       rom_mask,
  input  mem_pkg::rom_addr_t       saveram_mask,
  input  mem_pkg::rom_word_t       rom_dq_in,
  output snes_bus_pkg::snes_byte_t snes_data_out,
  output logic                     snes_data_oe,
  output logic                     mcu_rdy,
  output snes_bus_pkg::snes_byte_t mcu_rdata,
  output logic [22:0]              rom_addr,
  output logic                     rom_bhe,
  output logic                     rom_ble,
  output logic                     rom_we,
  output mem_pkg::rom_word_t       rom_dq_out,
  output logic                     rom_dq_oe
);

  snes_bus_pkg::snes_addr_t snes_addr;
  logic                     cycle_start;
  logic                     wr_start;
  logic                     wr_active;
  mem_pkg::rom_addr_t       mem_addr;
  snes_bus_pkg::snes_byte_t wr_byte;
  snes_bus_pkg::snes_byte_t rd_byte;

  rom_req_if snes_req ();
  rom_req_if mcu_req ();

  //////////////////////////////////////////////////
  // Requesters

  snes_bus_sync u_snes_bus_sync (
    .clk2         (clk2),
    .rst_n        (rst_n),
    .snes_addr_in (snes_addr_in),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_write   (snes_write),
    .snes_addr    (snes_addr),
    .cycle_start  (cycle_start),
    .wr_start     (wr_start),
    .wr_active    (wr_active)
  );

  snes_port u_snes_port (
    .clk2          (clk2),
    .rst_n         (rst_n),
    .snes_addr     (snes_addr),
    .cycle_start   (cycle_start),
    .wr_start      (wr_start),
    .snes_read     (snes_read),
    .snes_data_in  (snes_data_in),
    .rom_mask      (rom_mask),
    .saveram_mask  (saveram_mask),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .rom_req       (snes_req)
  );

  mcu_port u_mcu_port (
    .clk2      (clk2),
    .rst_n     (rst_n),
    .mcu_rrq   (mcu_rrq),
    .mcu_wrq   (mcu_wrq),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .mcu_rdy   (mcu_rdy),
    .mcu_rdata (mcu_rdata),
    .rom_req   (mcu_req)
  );

  //////////////////////////////////////////////////
  // Shared PSRAM

  rom_arbiter u_rom_arbiter (
    .clk2     (clk2),
    .rst_n    (rst_n),
    .rd_byte  (rd_byte),
    .snes_req (snes_req),
    .mcu_req  (mcu_req),
    .rom_addr (mem_addr),
    .wr_byte  (wr_byte),
    .rom_we   (rom_we)
  );

  rom_bus_drive u_rom_bus_drive (
    .rom_addr      (mem_addr),
    .wr_byte       (wr_byte),
    .rom_we        (rom_we),
    .rom_dq_in     (rom_dq_in),
    .rom_addr_word (rom_addr),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .rom_dq_out    (rom_dq_out),
    .rom_dq_oe     (rom_dq_oe),
    .rd_byte       (rd_byte)
  );

  // Cartridge never drives the console bus while the console writes
  a_no_drive_on_write: assert property (@(posedge clk2) disable iff (!rst_n)
    wr_active |-> !snes_data_oe);

endmodule

/* dv/psram_model.sv */
`timescale 1ns/10ps

module psram_model (
  input  logic [22:0]        addr,
  input  logic               bhe,
  input  logic               ble,
  input  logic               we,
  input  mem_pkg::rom_word_t dq_in,
  output mem_pkg::rom_word_t dq_out
);

  mem_pkg::rom_word_t mem [logic [22:0]];
  int unsigned        wr_count = 0;
  logic               we_fell = 1'b0;

  // Untouched words read as a mix of every address bit
  function automatic mem_pkg::rom_word_t fill_word(input logic [22:0] a);
    return a[15:0] ^ {a[22:16], a[22:14]} ^ 16'h5A3C;
  endfunction

  function automatic mem_pkg::rom_word_t word_at(input logic [22:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_word(a);
  endfunction

  task automatic load_byte(input logic [22:0] a, input logic lo_lane, input logic [7:0] b);
    mem_pkg::rom_word_t w;
    w = word_at(a);
    if (lo_lane) begin
      w[7:0] = b;
    end else begin
      w[15:8] = b;
    end
    mem[a] = w;
    wr_count++;
  endtask

  always @(negedge we) begin
    we_fell = 1'b1;
  end

  // Enabled lanes latch as write enable returns high
  always @(posedge we) begin
    mem_pkg::rom_word_t w;
    if (we_fell) begin
      w = word_at(addr);
      if (!ble) begin
        w[7:0] = dq_in[7:0];
      end
      if (!bhe) begin
        w[15:8] = dq_in[15:8];
      end
      mem[addr] = w;
      wr_count++;
    end
  end

  always @(addr or wr_count) begin
    dq_out = word_at(addr);
  end

endmodule

/* dv/tb_snes_cart.sv */
`timescale 1ns/10ps

`include "snes_cart_params.svh"

module tb_snes_cart;

  localparam int N_MCU      = 6;
  localparam int N_ROM      = 8;
  localparam int N_SAVE     = 4;
  localparam int N_PROT     = 3;
  localparam int N_NONE     = 2;
  localparam int N_PRE      = 2;
  localparam int TOTAL_OPS  = 2 * N_MCU + N_ROM + 2 * N_SAVE + 2 * N_PROT + N_NONE + 2 * N_PRE;
  localparam int HOLD       = 30;
  localparam int WAIT_LIMIT = 200;

  // PSRAM bus driven through the whole first wait of an MCU write
  localparam logic [7:0] MCU_WR_DRIVE = 8'd7;

  logic               clk2;
  logic               rst_n;
  logic [23:0]        snes_addr_in;
  logic               snes_read;
  logic               snes_write;
  logic               snes_cpu_clk;
  logic [7:0]         snes_data_in;
  logic               mcu_rrq;
  logic               mcu_wrq;
  logic [23:0]        mcu_addr;
  logic [7:0]         mcu_wdata;
  logic [23:0]        rom_mask;
  logic [23:0]        saveram_mask;
  mem_pkg::rom_word_t rom_dq_in;
  logic [7:0]         snes_data_out;
  logic               snes_data_oe;
  logic               mcu_rdy;
  logic [7:0]         mcu_rdata;
  logic [22:0]        rom_addr;
  logic               rom_bhe;
  logic               rom_ble;
  logic               rom_we;
  mem_pkg::rom_word_t rom_dq_out;
  logic               rom_dq_oe;

  // Expected PSRAM contents, by byte address
  logic [7:0] shadow [logic [23:0]];
  logic [7:0] act_q [$];
  logic [7:0] exp_q [$];
  string      msg_q [$];
  int         errors = 0;
  int         checks = 0;
  int         test_base = 0;
  int         oe_cycles = 0;

  snes_cart_top u_snes_cart_top (
    .clk2          (clk2),
    .rst_n         (rst_n),
    .snes_addr_in  (snes_addr_in),
    .snes_read     (snes_read),
    .snes_write    (snes_write),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_data_in  (snes_data_in),
    .mcu_rrq       (mcu_rrq),
    .mcu_wrq       (mcu_wrq),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .rom_mask      (rom_mask),
    .saveram_mask  (saveram_mask),
    .rom_dq_in     (rom_dq_in),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .mcu_rdy       (mcu_rdy),
    .mcu_rdata     (mcu_rdata),
    .rom_addr      (rom_addr),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .rom_we        (rom_we),
    .rom_dq_out    (rom_dq_out),
    .rom_dq_oe     (rom_dq_oe)
  );

  psram_model u_psram (
    .addr   (rom_addr),
    .bhe    (rom_bhe),
    .ble    (rom_ble),
    .we     (rom_we),
    .dq_in  (rom_dq_out),
    .dq_out (rom_dq_in)
  );

  initial begin
    clk2 = 1'b0;
    forever #5 clk2 = ~clk2;
  end

  //////////////////////////////////////////////////
  // Reference model

  function automatic logic [23:0] rand24();
    logic [31:0] r;
    r = $urandom;
    return r[23:0];
  endfunction

  function automatic logic [7:0] rand8();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  // LoROM map, save RAM window below $8000 in banks 70..7D
  function automatic logic [23:0] map_console(input logic [23:0] a,
                                              output snes_bus_pkg::mem_region_e region);
    logic [7:0]  bank;
    logic [23:0] offset;
    bank   = a[23:16];
    offset = {9'd0, a[14:0]};
    region = snes_bus_pkg::REGION_ROM;
    if (bank == 8'h7E || bank == 8'h7F) begin
      region = snes_bus_pkg::REGION_NONE;
      return 24'd0;
    end
    if (!a[15] && bank >= `SAVERAM_BANK_LO && bank <= `SAVERAM_BANK_HI) begin
      region = snes_bus_pkg::REGION_SAVERAM;
      return `SAVERAM_BASE + (offset & saveram_mask);
    end
    return {2'b00, bank[6:0], a[14:0]} & rom_mask;
  endfunction

  function automatic logic [7:0] expected_byte(input logic [23:0] a);
    snes_bus_pkg::mem_region_e region;
    logic [23:0]               m;
    m = map_console(a, region);
    if (shadow.exists(m)) begin
      return shadow[m];
    end
    return 8'h00;
  endfunction

  // Odd byte addresses sit in the low lane
  task automatic ensure_byte(input logic [23:0] a);
    logic [7:0] v;
    if (!shadow.exists(a)) begin
      v = rand8();
      shadow[a] = v;
      u_psram.load_byte(a[23:1], a[0], v);
    end
  endtask

  task automatic queue_check(input logic [7:0] act, input logic [7:0] exp, input string msg);
    act_q.push_back(act);
    exp_q.push_back(exp);
    msg_q.push_back(msg);
  endtask

  always @(negedge clk2) begin
    logic [7:0] act;
    logic [7:0] exp;
    string      msg;
    while (act_q.size() > 0) begin
      act = act_q.pop_front();
      exp = exp_q.pop_front();
      msg = msg_q.pop_front();
      checks++;
      assert (act == exp) else begin
        $display("ERR %0t: %s, got %02h expected %02h", $time, msg, act, exp);
        errors++;
      end
    end
  end

  // Cycles in which the PSRAM data bus is driven
  always @(negedge clk2) begin
    if (rom_dq_oe === 1'b1) begin
      oe_cycles++;
    end
  end

  //////////////////////////////////////////////////
  // Bus tasks

  task automatic mcu_issue(input logic wr, input logic [23:0] a, input logic [7:0] d);
    @(posedge clk2);
    mcu_rrq   <= !wr;
    mcu_wrq   <= wr;
    mcu_addr  <= a;
    mcu_wdata <= d;
    @(posedge clk2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge clk2);
    queue_check({7'd0, mcu_rdy}, 8'd0, "mcu_rdy low after request");
  endtask

  task automatic mcu_wait();
    int n;
    n = 0;
    while (!mcu_rdy && n < WAIT_LIMIT) begin
      @(negedge clk2);
      n++;
    end
    if (!mcu_rdy) begin
      $display("Timed out at %0t waiting for mcu_rdy to return high", $time);
      errors++;
    end
  endtask

  task automatic mcu_write(input logic [23:0] a, input logic [7:0] d);
    int oe_start;
    int oe_len;
    oe_start = oe_cycles;
    mcu_issue(1'b1, a, d);
    mcu_wait();
    oe_len = oe_cycles - oe_start;
    queue_check(oe_len[7:0], MCU_WR_DRIVE, "rom_dq_oe cycles in mcu write");
    shadow[a] = d;
  endtask

  task automatic mcu_read_check(input logic [23:0] a, input string what);
    mcu_issue(1'b0, a, 8'h00);
    mcu_wait();
    queue_check(mcu_rdata, shadow[a], what);
  endtask

  task automatic set_masks(input logic [23:0] rm, input logic [23:0] sm);
    @(posedge clk2);
    rom_mask     <= rm;
    saveram_mask <= sm;
    @(posedge clk2);
  endtask

  // Address settles and the CPU clock sits low long enough for a clean edge
  task automatic console_setup(input logic [23:0] a);
    @(posedge clk2);
    snes_addr_in <= a;
    snes_cpu_clk <= 1'b0;
    repeat (10) @(posedge clk2);
  endtask

  task automatic console_read_run(output logic [7:0] data, output logic oe);
    @(posedge clk2);
    snes_cpu_clk <= 1'b1;
    snes_read    <= 1'b0;
    repeat (HOLD - 1) @(posedge clk2);
    @(negedge clk2);
    data = snes_data_out;
    oe   = snes_data_oe;
    @(posedge clk2);
    snes_read    <= 1'b1;
    snes_cpu_clk <= 1'b0;
  endtask

  task automatic console_write(input logic [23:0] a, input logic [7:0] d);
    snes_bus_pkg::mem_region_e region;
    logic [23:0]               m;
    @(posedge clk2);
    snes_data_in <= d;
    console_setup(a);
    snes_write <= 1'b0;
    repeat (HOLD) @(posedge clk2);
    snes_write <= 1'b1;
    m = map_console(a, region);
    if (region == snes_bus_pkg::REGION_SAVERAM) begin
      shadow[m] = d;
    end
  endtask

  function automatic logic [23:0] rom_region_addr();
    logic [23:0] a;
    a     = rand24();
    a[15] = 1'b1;
    if (a[23:17] == 7'h3F) begin
      a[23] = 1'b1;
    end
    return a;
  endfunction

  task automatic end_test(input int num, input string name);
    repeat (2) @(posedge clk2);
    $display("Test %0d %s: %0d errors", num, name, errors - test_base);
    test_base = errors;
  endtask

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    logic [23:0]               a;
    logic [23:0]               b;
    logic [23:0]               m;
    logic [7:0]                d;
    logic [7:0]                got;
    logic                      oe;
    logic [31:0]               r;
    logic [23:0]               addrs [N_MCU];
    snes_bus_pkg::mem_region_e region;
    void'($urandom(29));
    rst_n        = 1'b0;
    snes_addr_in = 24'd0;
    snes_read    = 1'b1;
    snes_write   = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_data_in = 8'd0;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mcu_addr     = 24'd0;
    mcu_wdata    = 8'd0;
    rom_mask     = 24'h3FFFFF;
    saveram_mask = 24'h001FFF;
    repeat (4) @(posedge clk2);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk2);

    for (int i = 0; i < N_MCU; i++) begin
      addrs[i] = rand24();
      mcu_write(addrs[i], rand8());
    end
    for (int i = 0; i < N_MCU; i++) begin
      mcu_read_check(addrs[i], "mcu read-back");
    end
    end_test(1, "mcu write then read");

    for (int i = 0; i < N_ROM; i++) begin
      set_masks((24'd1 << (18 + $urandom_range(4, 0))) - 24'd1, saveram_mask);
      a = rom_region_addr();
      m = map_console(a, region);
      ensure_byte(m);
      console_setup(a);
      console_read_run(got, oe);
      queue_check(got, expected_byte(a), "rom read data");
      queue_check({7'd0, oe}, 8'd1, "snes_data_oe during rom read");
    end
    end_test(2, "console rom reads");

    for (int i = 0; i < N_SAVE; i++) begin
      set_masks(rom_mask, (24'd1 << (13 + $urandom_range(2, 0))) - 24'd1);
      r = $urandom_range(13, 0);
      a = rand24();
      a[23:16] = `SAVERAM_BANK_LO + r[7:0];
      a[15] = 1'b0;
      console_write(a, rand8());
      m = map_console(a, region);
      mcu_read_check(m, "save ram read-back");
    end
    end_test(3, "console save ram writes");

    for (int i = 0; i < N_PROT; i++) begin
      a = rom_region_addr();
      m = map_console(a, region);
      ensure_byte(m);
      d = ~shadow[m];
      console_write(a, d);
      mcu_read_check(m, "rom byte after blocked write");
    end
    end_test(4, "rom write protection");

    for (int i = 0; i < N_NONE; i++) begin
      a = rand24();
      a[23:17] = 7'h3F;
      console_setup(a);
      console_read_run(got, oe);
      queue_check({7'd0, oe}, 8'd0, "snes_data_oe in wram bank");
    end
    end_test(5, "unmapped banks");

    for (int i = 0; i < N_PRE; i++) begin
      a = rom_region_addr();
      m = map_console(a, region);
      ensure_byte(m);
      b = rand24();
      ensure_byte(b);
      console_setup(a);
      mcu_issue(1'b0, b, 8'h00);
      console_read_run(got, oe);
      queue_check(got, expected_byte(a), "console read during mcu access");
      mcu_wait();
      queue_check(mcu_rdata, shadow[b], "preempted mcu read");
    end
    end_test(6, "console preemption");

    repeat (3) @(posedge clk2);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (400 * TOTAL_OPS) @(posedge clk2);
    $display("Watchdog expired after %0d cycles, the run did not finish", 400 * TOTAL_OPS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+src
src/snes_bus_pkg.sv
src/mem_pkg.sv
src/rom_req_if.sv
src/snes_bus_sync.sv
src/snes_port.sv
src/mcu_port.sv
src/rom_arbiter.sv
src/rom_bus_drive.sv
src/snes_cart_top.sv
dv/psram_model.sv
dv/tb_snes_cart.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_snes_cart \
  --Mdir obj_dir \
  -f compile.f

./obj_dir/Vtb_snes_cart | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
